// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then scan the log for failure
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module proc_tb \
   -o proc_sim -f verilog.f \
   && ./obj_dir/proc_sim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && exit 1
exit 0

// ==== src/apb_debug_port.sv ====
//------------------------------------------------------------
// APB debug slave, zero wait states
// address decode, instruction load, read mux
// run flag and sticky bus error
//------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module apb_debug_port (
   input  wire                      clk,
   input  wire                      rst,
   input  wire cpu_pkg::apb_addr_t  paddr,
   input  wire                      psel,
   input  wire                      penable,
   input  wire                      pwrite,
   input  wire cpu_pkg::word_t      pwdata,
   output cpu_pkg::word_t           prdata,
   output logic                     pready,
   output logic                     pslverr,
   input  wire                      halted,
   output logic                     bus_err,
   output cpu_pkg::imem_wr_t        imem_wr,
   output logic                     run,
   output cpu_pkg::reg_idx_t        reg_dbg_idx,
   input  wire cpu_pkg::word_t      reg_dbg_data,
   output cpu_pkg::dmem_addr_t      dmem_dbg_addr,
   input  wire cpu_pkg::word_t      dmem_dbg_data
);

   logic access;
   logic is_imem;
   logic is_reg;
   logic is_dmem;
   logic is_ctrl;
   logic bad;

   assign access  = psel && penable;
   assign is_imem = paddr[11:8] == cpu_pkg::ADDR_IMEM[11:8];
   assign is_reg  = paddr[11:3] == cpu_pkg::ADDR_REG[11:3];
   assign is_dmem = paddr[11:8] == cpu_pkg::ADDR_DMEM[11:8];
   assign is_ctrl = paddr == cpu_pkg::ADDR_CTRL;

   // imem is write only, regs and dmem read only
   always_comb begin
      if (pwrite)
         bad = !(is_imem || is_ctrl) || (is_imem && run);
      else
         bad = !(is_reg || is_dmem || is_ctrl);
   end

   assign pready  = 1'b1;
   assign pslverr = access && bad;

   always_comb begin
      imem_wr.en   = access && pwrite && is_imem && !run;
      imem_wr.addr = paddr[cpu_pkg::IMEM_AW-1:0];
      imem_wr.data = pwdata;
   end

   assign reg_dbg_idx   = paddr[2:0];
   assign dmem_dbg_addr = paddr[cpu_pkg::DMEM_AW-1:0];

   always_comb begin
      if (is_reg)
         prdata = reg_dbg_data;
      else if (is_dmem)
         prdata = dmem_dbg_data;
      else if (is_ctrl)
         prdata = {14'b0, bus_err, halted};
      else
         prdata = '0;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         run     <= 1'b0;
         bus_err <= 1'b0;
      end else begin
         // halt wins over a start in the same cycle
         if (halted)
            run <= 1'b0;
         else if (access && pwrite && is_ctrl && pwdata[0])
            run <= 1'b1;
         if (pslverr)
            bus_err <= 1'b1;
      end
   end

   assert property (@(posedge clk) disable iff (rst) $rose(penable) |-> psel)
      else $error("penable rose without psel");

endmodule

`default_nettype wire

// ==== src/cpu_pkg.sv ====
//------------------------------------------------------------
// shared types for the four stage core
// opcode, alu, branch and write-back enums
// stage packets, register and imem write packets
// debug address map and memory sizes
//------------------------------------------------------------
`default_nettype none

package cpu_pkg;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_idx_t;
   typedef logic [11:0] apb_addr_t;

   localparam int IMEM_WORDS = 256;
   localparam int DMEM_WORDS = 256;
   localparam int IMEM_AW    = $clog2(IMEM_WORDS);
   localparam int DMEM_AW    = $clog2(DMEM_WORDS);

   typedef logic [IMEM_AW-1:0] imem_addr_t;
   typedef logic [DMEM_AW-1:0] dmem_addr_t;

   // debug port address map
   localparam apb_addr_t ADDR_IMEM = 12'h000;
   localparam apb_addr_t ADDR_REG  = 12'h100;
   localparam apb_addr_t ADDR_DMEM = 12'h200;
   localparam apb_addr_t ADDR_CTRL = 12'h300;

   // instruction bits 15:11
   typedef enum logic [4:0] {
      OP_HALT = 5'b00000,
      OP_NOP  = 5'b00001,
      OP_J    = 5'b00100,
      OP_ADDI = 5'b01000,
      OP_BEQZ = 5'b01100,
      OP_BNEZ = 5'b01101,
      OP_ST   = 5'b10000,
      OP_LD   = 5'b10001,
      OP_LBI  = 5'b11000,
      OP_ADD  = 5'b11100,
      OP_SUB  = 5'b11101,
      OP_AND  = 5'b11110,
      OP_XOR  = 5'b11111
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_XOR,
      ALU_PASSB
   } alu_op_e;

   typedef enum logic [1:0] {
      WB_ALU,
      WB_MEM,
      WB_NONE
   } wb_sel_e;

   typedef enum logic [1:0] {
      BR_NONE,
      BR_EQZ,
      BR_NEZ
   } br_kind_e;

   typedef struct packed {
      logic  valid;
      word_t pc;
      word_t instr;
   } fetch_pkt_t;

   typedef struct packed {
      logic     valid;
      word_t    pc_inc;
      word_t    a;
      word_t    b;
      reg_idx_t rs;
      reg_idx_t rt;
      logic     has_rs;
      logic     has_rt;
      word_t    imm;
      alu_op_e  alu_op;
      logic     uses_imm;
      wb_sel_e  wb_sel;
      reg_idx_t rd;
      logic     mem_wr;
      br_kind_e br_kind;
      logic     jmp;
      logic     halt;
      logic     illegal;
   } dec_pkt_t;

   typedef struct packed {
      logic     valid;
      logic     wr_en;
      reg_idx_t rd;
      word_t    data;
      logic     halt;
      logic     illegal;
   } wb_pkt_t;

   typedef struct packed {
      logic     en;
      reg_idx_t idx;
      word_t    data;
   } reg_wr_t;

   typedef struct packed {
      logic       en;
      imem_addr_t addr;
      word_t      data;
   } imem_wr_t;

endpackage

`default_nettype wire

// ==== src/decode.sv ====
//------------------------------------------------------------
// decode stage
// opcode decode and immediate sign extension
// eight entry register file with write bypass
// decode to execute packet register
//------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module decode (
   input  wire                       clk,
   input  wire                       rst,
   input  wire cpu_pkg::fetch_pkt_t  fpkt,
   input  wire                       redirect,
   input  wire cpu_pkg::reg_wr_t     reg_wr,
   input  wire cpu_pkg::reg_idx_t    reg_dbg_idx,
   output cpu_pkg::word_t            reg_dbg_data,
   output cpu_pkg::dec_pkt_t         dpkt
);

   cpu_pkg::word_t    regs [8];
   cpu_pkg::opcode_e  op;
   cpu_pkg::word_t    imm5;
   cpu_pkg::word_t    imm8;
   cpu_pkg::word_t    imm11;
   cpu_pkg::dec_pkt_t nxt;

   // same cycle write shows up on the read
   function automatic cpu_pkg::word_t rf_read(input cpu_pkg::reg_idx_t idx);
      if (reg_wr.en && reg_wr.idx == idx)
         return reg_wr.data;
      return regs[idx];
   endfunction

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 8; i++)
            regs[i] <= '0;
      end else if (reg_wr.en) begin
         regs[reg_wr.idx] <= reg_wr.data;
      end
   end

   assign op    = cpu_pkg::opcode_e'(fpkt.instr[15:11]);
   assign imm5  = {{11{fpkt.instr[4]}}, fpkt.instr[4:0]};
   assign imm8  = {{8{fpkt.instr[7]}}, fpkt.instr[7:0]};
   assign imm11 = {{5{fpkt.instr[10]}}, fpkt.instr[10:0]};

   always_comb begin
      reg_dbg_data = rf_read(reg_dbg_idx);
   end

   always_comb begin
      nxt         = '0;
      nxt.valid   = fpkt.valid;
      nxt.pc_inc  = fpkt.pc + 16'd1;
      nxt.rs      = fpkt.instr[10:8];
      nxt.rt      = fpkt.instr[7:5];
      nxt.a       = rf_read(fpkt.instr[10:8]);
      nxt.b       = rf_read(fpkt.instr[7:5]);
      nxt.alu_op  = cpu_pkg::ALU_ADD;
      nxt.wb_sel  = cpu_pkg::WB_NONE;
      nxt.br_kind = cpu_pkg::BR_NONE;
      case (op)
         cpu_pkg::OP_NOP: begin
         end
         cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_XOR: begin
            nxt.has_rs = 1'b1;
            nxt.has_rt = 1'b1;
            nxt.wb_sel = cpu_pkg::WB_ALU;
            nxt.rd     = fpkt.instr[4:2];
            case (op)
               cpu_pkg::OP_SUB: nxt.alu_op = cpu_pkg::ALU_SUB;
               cpu_pkg::OP_AND: nxt.alu_op = cpu_pkg::ALU_AND;
               cpu_pkg::OP_XOR: nxt.alu_op = cpu_pkg::ALU_XOR;
               default:         nxt.alu_op = cpu_pkg::ALU_ADD;
            endcase
         end
         cpu_pkg::OP_ADDI, cpu_pkg::OP_LD: begin
            nxt.has_rs   = 1'b1;
            nxt.imm      = imm5;
            nxt.uses_imm = 1'b1;
            nxt.rd       = fpkt.instr[7:5];
            nxt.wb_sel   = (op == cpu_pkg::OP_LD) ? cpu_pkg::WB_MEM : cpu_pkg::WB_ALU;
         end
         cpu_pkg::OP_ST: begin
            nxt.has_rs   = 1'b1;
            nxt.has_rt   = 1'b1;
            nxt.imm      = imm5;
            nxt.uses_imm = 1'b1;
            nxt.mem_wr   = 1'b1;
         end
         cpu_pkg::OP_LBI: begin
            nxt.imm      = imm8;
            nxt.uses_imm = 1'b1;
            nxt.alu_op   = cpu_pkg::ALU_PASSB;
            nxt.wb_sel   = cpu_pkg::WB_ALU;
            nxt.rd       = fpkt.instr[10:8];
         end
         cpu_pkg::OP_BEQZ, cpu_pkg::OP_BNEZ: begin
            nxt.has_rs  = 1'b1;
            nxt.imm     = imm8;
            nxt.br_kind = (op == cpu_pkg::OP_BEQZ) ? cpu_pkg::BR_EQZ : cpu_pkg::BR_NEZ;
         end
         cpu_pkg::OP_J: begin
            nxt.imm = imm11;
            nxt.jmp = 1'b1;
         end
         // halt and trap jump back onto themselves, flushing younger work
         cpu_pkg::OP_HALT: begin
            nxt.halt = 1'b1;
            nxt.jmp  = 1'b1;
            nxt.imm  = '1;
         end
         default: begin
            nxt.illegal = 1'b1;
            nxt.jmp     = 1'b1;
            nxt.imm     = '1;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      dpkt <= nxt;
      if (rst || redirect)
         dpkt.valid <= 1'b0;
   end

   assert property (@(posedge clk) disable iff (rst) !$isunknown(reg_wr.en))
      else $error("register write enable unknown");

endmodule

`default_nettype wire

// ==== src/execute.sv ====
//------------------------------------------------------------
// execute stage
// forwarding from result, alu, branch resolve
// data memory and the execute to result packet register
//------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module execute (
   input  wire                       clk,
   input  wire                       rst,
   input  wire cpu_pkg::dec_pkt_t    dpkt,
   input  wire cpu_pkg::reg_wr_t     fwd,
   input  wire cpu_pkg::dmem_addr_t  dmem_dbg_addr,
   output cpu_pkg::word_t            dmem_dbg_data,
   output logic                      redirect,
   output cpu_pkg::word_t            target,
   output cpu_pkg::wb_pkt_t          wpkt
);

   cpu_pkg::word_t      dmem [cpu_pkg::DMEM_WORDS];
   cpu_pkg::word_t      opa;
   cpu_pkg::word_t      rt_val;
   cpu_pkg::word_t      opb;
   cpu_pkg::word_t      alu_out;
   cpu_pkg::word_t      mem_rd;
   cpu_pkg::dmem_addr_t mem_addr;
   logic                taken;
   cpu_pkg::wb_pkt_t    nxt;

   assign opa    = (fwd.en && dpkt.has_rs && fwd.idx == dpkt.rs) ? fwd.data : dpkt.a;
   assign rt_val = (fwd.en && dpkt.has_rt && fwd.idx == dpkt.rt) ? fwd.data : dpkt.b;
   assign opb    = dpkt.uses_imm ? dpkt.imm : rt_val;

   always_comb begin
      case (dpkt.alu_op)
         cpu_pkg::ALU_ADD:   alu_out = opa + opb;
         cpu_pkg::ALU_SUB:   alu_out = opa - opb;
         cpu_pkg::ALU_AND:   alu_out = opa & opb;
         cpu_pkg::ALU_XOR:   alu_out = opa ^ opb;
         cpu_pkg::ALU_PASSB: alu_out = opb;
         default:            alu_out = '0;
      endcase
   end

   // load and store address is rs + imm
   assign mem_addr      = alu_out[cpu_pkg::DMEM_AW-1:0];
   assign mem_rd        = dmem[mem_addr];
   assign dmem_dbg_data = dmem[dmem_dbg_addr];

   always_ff @(posedge clk) begin
      if (dpkt.valid && dpkt.mem_wr)
         dmem[mem_addr] <= rt_val;
   end

   always_comb begin
      case (dpkt.br_kind)
         cpu_pkg::BR_EQZ: taken = (opa == '0);
         cpu_pkg::BR_NEZ: taken = (opa != '0);
         default:         taken = 1'b0;
      endcase
   end

   assign redirect = dpkt.valid && (dpkt.jmp || taken);
   assign target   = dpkt.pc_inc + dpkt.imm;

   always_comb begin
      nxt.valid   = dpkt.valid;
      nxt.wr_en   = dpkt.wb_sel != cpu_pkg::WB_NONE;
      nxt.rd      = dpkt.rd;
      nxt.data    = (dpkt.wb_sel == cpu_pkg::WB_MEM) ? mem_rd : alu_out;
      nxt.halt    = dpkt.halt;
      nxt.illegal = dpkt.illegal;
   end

   always_ff @(posedge clk) begin
      wpkt <= nxt;
      if (rst)
         wpkt.valid <= 1'b0;
   end

   // the packet behind a redirect arrives squashed
   assert property (@(posedge clk) disable iff (rst) redirect |=> !dpkt.valid)
      else $error("packet after a redirect was not squashed");

endmodule

`default_nettype wire

// ==== src/fetch.sv ====
//------------------------------------------------------------
// fetch stage
// pc, instruction memory and the fetch packet register
//------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module fetch (
   input  wire                     clk,
   input  wire                     rst,
   input  wire                     run,
   input  wire cpu_pkg::imem_wr_t  imem_wr,
   input  wire                     redirect,
   input  wire cpu_pkg::word_t     target,
   input  wire                     halted,
   output cpu_pkg::fetch_pkt_t     pkt
);

   cpu_pkg::word_t imem [cpu_pkg::IMEM_WORDS];
   cpu_pkg::word_t pc;
   logic           active;

   assign active = run && !halted;

   // loaded only over the debug port
   always_ff @(posedge clk) begin
      if (imem_wr.en)
         imem[imem_wr.addr] <= imem_wr.data;
   end

   always_ff @(posedge clk) begin
      pkt.pc    <= pc;
      pkt.instr <= imem[pc[cpu_pkg::IMEM_AW-1:0]];
      if (rst) begin
         pc        <= '0;
         pkt.valid <= 1'b0;
      end else if (redirect) begin
         pc        <= target;
         pkt.valid <= 1'b0;
      end else if (active) begin
         pc        <= pc + 16'd1;
         pkt.valid <= 1'b1;
      end else begin
         pkt.valid <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== src/proc.sv ====
//------------------------------------------------------------
// top level of the pipelined core
// four stages plus the APB debug port
//------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module proc (
   input  wire                      clk,
   input  wire                      rst,
   input  wire cpu_pkg::apb_addr_t  paddr,
   input  wire                      psel,
   input  wire                      penable,
   input  wire                      pwrite,
   input  wire cpu_pkg::word_t      pwdata,
   output cpu_pkg::word_t           prdata,
   output logic                     pready,
   output logic                     pslverr,
   output logic                     err
);

   cpu_pkg::imem_wr_t   imem_wr;
   logic                run;
   logic                halted;
   logic                bus_err;
   logic                illegal_err;
   cpu_pkg::reg_idx_t   reg_dbg_idx;
   cpu_pkg::word_t      reg_dbg_data;
   cpu_pkg::dmem_addr_t dmem_dbg_addr;
   cpu_pkg::word_t      dmem_dbg_data;
   cpu_pkg::fetch_pkt_t fpkt;
   cpu_pkg::dec_pkt_t   dpkt;
   cpu_pkg::wb_pkt_t    wpkt;
   cpu_pkg::reg_wr_t    reg_wr;
   logic                redirect;
   cpu_pkg::word_t      target;

   assign err = bus_err | illegal_err;

   apb_debug_port i_dbg (
      .clk           (clk),
      .rst           (rst),
      .paddr         (paddr),
      .psel          (psel),
      .penable       (penable),
      .pwrite        (pwrite),
      .pwdata        (pwdata),
      .prdata        (prdata),
      .pready        (pready),
      .pslverr       (pslverr),
      .halted        (halted),
      .bus_err       (bus_err),
      .imem_wr       (imem_wr),
      .run           (run),
      .reg_dbg_idx   (reg_dbg_idx),
      .reg_dbg_data  (reg_dbg_data),
      .dmem_dbg_addr (dmem_dbg_addr),
      .dmem_dbg_data (dmem_dbg_data)
   );

   fetch i_fetch (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .imem_wr  (imem_wr),
      .redirect (redirect),
      .target   (target),
      .halted   (halted),
      .pkt      (fpkt)
   );

   decode i_decode (
      .clk          (clk),
      .rst          (rst),
      .fpkt         (fpkt),
      .redirect     (redirect),
      .reg_wr       (reg_wr),
      .reg_dbg_idx  (reg_dbg_idx),
      .reg_dbg_data (reg_dbg_data),
      .dpkt         (dpkt)
   );

   // result write data doubles as the forwarding path
   execute i_execute (
      .clk           (clk),
      .rst           (rst),
      .dpkt          (dpkt),
      .fwd           (reg_wr),
      .dmem_dbg_addr (dmem_dbg_addr),
      .dmem_dbg_data (dmem_dbg_data),
      .redirect      (redirect),
      .target        (target),
      .wpkt          (wpkt)
   );

   result i_result (
      .clk         (clk),
      .rst         (rst),
      .wpkt        (wpkt),
      .reg_wr      (reg_wr),
      .halted      (halted),
      .illegal_err (illegal_err)
   );

endmodule

`default_nettype wire

// ==== src/result.sv ====
//------------------------------------------------------------
// result stage
// register write packet, halt capture, illegal op trap
//------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module result (
   input  wire                     clk,
   input  wire                     rst,
   input  wire cpu_pkg::wb_pkt_t   wpkt,
   output cpu_pkg::reg_wr_t        reg_wr,
   output logic                    halted,
   output logic                    illegal_err
);

   always_ff @(posedge clk) begin
      if (rst) begin
         halted      <= 1'b0;
         illegal_err <= 1'b0;
      end else if (wpkt.valid) begin
         // a trap also stops the core
         if (wpkt.halt || wpkt.illegal)
            halted <= 1'b1;
         if (wpkt.illegal)
            illegal_err <= 1'b1;
      end
   end

   always_comb begin
      reg_wr.en   = wpkt.valid && wpkt.wr_en && !halted && !illegal_err;
      reg_wr.idx  = wpkt.rd;
      reg_wr.data = wpkt.data;
   end

   // the flush behind halt leaves nothing that writes
   assert property (@(posedge clk) disable iff (rst) halted |-> !(wpkt.valid && wpkt.wr_en))
      else $error("register write packet reached result after halt");

endmodule

`default_nettype wire

// ==== test/proc_golden.txt ====
# W addr data pslverr : APB write, expected pslverr
# R addr data pslverr : APB read, expected prdata and pslverr ; H : poll until halted
W 000 C105 0
W 001 C2FD 0
W 002 E14C 0
W 003 EB30 0
W 004 F434 0
W 005 FD98 0
W 006 46FC 0
W 007 8183 0
W 008 8162 0
W 009 8902 0
W 00A E0EC 0
W 00B C203 0
W 00C C400 0
W 00D 4482 0
W 00E 425F 0
W 00F 6AFD 0
W 010 45A1 0
W 011 46C1 0
W 012 6402 0
W 013 4121 0
W 014 2002 0
W 015 C711 0
W 016 C322 0
W 017 1000 0
W 018 C055 0
R 300 0000 0
W 300 0001 0
W 0FF 0800 1
R 300 0002 0
H
R 300 0003 0
W 101 1234 1
R 005 0000 1
R 7F0 0000 1
W 500 0001 1
R 100 0002 0
R 101 0006 0
R 102 0000 0
R 103 FFF6 0
R 104 0006 0
R 105 0006 0
R 106 FFF9 0
R 107 FFF4 0
R 207 0002 0
R 208 FFFD 0
R 300 0003 0

// ==== test/proc_tb.sv ====
//------------------------------------------------------------
// testbench for the pipelined core
// golden file reader and APB master tasks
// compare tasks and cycle limit
//------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module proc_tb;

   logic               clk;
   logic               rst;
   cpu_pkg::apb_addr_t paddr;
   logic               psel;
   logic               penable;
   logic               pwrite;
   cpu_pkg::word_t     pwdata;
   cpu_pkg::word_t     prdata;
   logic               pready;
   logic               pslverr;
   logic               err;

   string              lines[$];
   logic [7:0]         lfsr;
   int                 errors;
   int                 cycles;
   int                 limit;

   proc i_dut (
      .clk     (clk),
      .rst     (rst),
      .paddr   (paddr),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .err     (err)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (limit > 0 && cycles > limit) begin
         $display("timeout: run did not end within %0d cycles", limit);
         $display("sim failed");
         $finish;
      end
   end

   // taps 8,6,5,4
   function automatic logic [7:0] lfsr_step(input logic [7:0] s);
      return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
   endfunction

   function automatic logic is_command(input string line);
      byte c;
      if (line.len() == 0)
         return 1'b0;
      c = line.getc(0);
      return !(c == "#" || c == "\n" || c == "\r" || c == " ");
   endfunction

   task automatic check_word(input string name, input cpu_pkg::word_t got,
                             input cpu_pkg::word_t exp);
      if (got !== exp) begin
         errors++;
         $display("Fail %s got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         errors++;
         $display("Fail %s got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   // 0 to 3 idle cycles, one lfsr step per bit
   task automatic insert_idle();
      int n;
      lfsr = lfsr_step(lfsr);
      n = int'(lfsr[0]);
      lfsr = lfsr_step(lfsr);
      n = n * 2 + int'(lfsr[0]);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   // called 1 ns after a rising edge, returns at the same phase
   task automatic apb_transfer(input cpu_pkg::apb_addr_t addr, input logic write,
                               input cpu_pkg::word_t wdata, output cpu_pkg::word_t rdata,
                               output logic slverr, output logic err_pin);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(negedge clk);
      rdata   = prdata;
      slverr  = pslverr;
      err_pin = err;
      check_flag("pready", pready, 1'b1);
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic wait_halt();
      cpu_pkg::word_t rdata;
      logic           slverr;
      logic           err_pin;
      rdata = '0;
      while (rdata[0] !== 1'b1) begin
         insert_idle();
         apb_transfer(cpu_pkg::ADDR_CTRL, 1'b0, '0, rdata, slverr, err_pin);
         check_flag("pslverr", slverr, 1'b0);
      end
   endtask

   task automatic run_line(input string line);
      byte                kind;
      int                 n;
      int                 a;
      int                 d;
      int                 e;
      cpu_pkg::apb_addr_t addr;
      cpu_pkg::word_t     rdata;
      logic               slverr;
      logic               err_pin;
      kind = line.getc(0);
      a = 0;
      d = 0;
      e = 0;
      n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, d, e);
      addr = a[11:0];
      if (kind == "H") begin
         wait_halt();
      end else if ((kind == "W" || kind == "R") && n == 3) begin
         insert_idle();
         apb_transfer(addr, kind == "W", d[15:0], rdata, slverr, err_pin);
         check_flag($sformatf("pslverr@%h", addr), slverr, e[0]);
         if (kind == "R") begin
            check_word($sformatf("prdata@%h", addr), rdata, d[15:0]);
            // control reads also show on the err pin
            if (addr == cpu_pkg::ADDR_CTRL)
               check_flag("err", err_pin, d[1]);
         end
      end else begin
         errors++;
         $display("golden line not understood: %s", line);
      end
   endtask

   initial begin
      int    fd;
      int    n;
      string line;
      clk     = 1'b0;
      rst     = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      lfsr    = 8'd39;
      errors  = 0;
      cycles  = 0;
      limit   = 0;
      fd = $fopen("test/proc_golden.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("could not open the golden file test/proc_golden.txt");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && is_command(line))
               lines.push_back(line);
         end
         $fclose(fd);
      end
      if (lines.size() == 0) begin
         errors++;
         $display("golden file holds no commands");
      end
      limit = 60 * lines.size() + 5;
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;
      foreach (lines[i])
         run_line(lines[i]);
      $display("errors: %0d in %0d golden lines", errors, lines.size());
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/cpu_pkg.sv
src/apb_debug_port.sv
src/fetch.sv
src/decode.sv
src/execute.sv
src/result.sv
src/proc.sv
test/proc_tb.sv
